//--- flist.f
hdl/chess_pkg.sv
hdl/play_pkg.sv
hdl/board_store.sv
hdl/move_check.sv
hdl/game_ctrl.sv
hdl/board_view.sv
hdl/play_top.sv
testbench/tb_clk_gen.sv
testbench/tb_play.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_play
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_play.sv
module tb_play;
    import chess_pkg::*;
    import play_pkg::*;

    // 40 presses of about 5 cycles each, times ten
    localparam int PRESSES      = 40;
    localparam int PRESS_CYCLES = 5;
    localparam int MAX_CYCLES   = PRESSES * PRESS_CYCLES * 10;

    logic        clk;
    logic        rstn;
    coord_t      cursor_x;
    coord_t      cursor_y;
    logic        is_pressed;
    game_state_t state;
    view_flat_t  board_data;
    sound_t      sound_code;
    logic        play_sound;

    int errors  = 0;
    int presses = 0;
    int cycles  = 0;

    // reference board and selection
    cell_t       ref_cell [BOARD_CELLS];
    logic        ref_sel;
    coord_t      ref_sx;
    coord_t      ref_sy;
    side_t       ref_turn;
    game_state_t ref_state;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    play_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .is_pressed (is_pressed),
        .state      (state),
        .board_data (board_data),
        .sound_code (sound_code),
        .play_sound (play_sound)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // -------------------- reference model
    function automatic cell_t occupied_cell(input side_t side, input piece_t piece);
        return {3'b000, 1'b1, side, piece};
    endfunction

    function automatic int sq_of(input coord_t x, input coord_t y);
        return int'(y) * 8 + int'(x);
    endfunction

    task automatic load_layout();
        piece_t back [8];
        back = '{ROOK, KNIGHT, BISHOP, QUEEN, KING, BISHOP, KNIGHT, ROOK};
        for (int sq = 0; sq < BOARD_CELLS; sq++) begin
            ref_cell[sq] = 8'h00;
        end
        for (int f = 0; f < 8; f++) begin
            ref_cell[f]      = occupied_cell(WHITE, back[f]);
            ref_cell[8 + f]  = occupied_cell(WHITE, PAWN);
            ref_cell[48 + f] = occupied_cell(BLACK, PAWN);
            ref_cell[56 + f] = occupied_cell(BLACK, back[f]);
        end
        ref_sel   = 1'b0;
        ref_sx    = '0;
        ref_sy    = '0;
        ref_turn  = WHITE;
        ref_state = PLAY_STATE;
    endtask

    function automatic void update_ref(input coord_t x, input coord_t y, input sound_t snd);
        int src;
        int dst;
        src = sq_of(ref_sx, ref_sy);
        dst = sq_of(x, y);
        case (snd)
            SND_SELECT: begin
                ref_sel = 1'b1;
                ref_sx  = x;
                ref_sy  = y;
            end
            SND_DESELECT: begin
                ref_sel = 1'b0;
            end
            SND_MOVE, SND_CAPTURE, SND_GAMEOVER: begin
                ref_cell[dst] = ref_cell[src];    // captured piece just vanishes
                ref_cell[src] = 8'h00;
                ref_sel       = 1'b0;
                if (snd == SND_GAMEOVER) begin
                    ref_state = (ref_turn == WHITE) ? WHITE_WIN_STATE : BLACK_WIN_STATE;
                end
                ref_turn = ~ref_turn;
            end
            default: begin
            end
        endcase
    endfunction

    function automatic view_word_t expect_word(input int sq);
        logic at_sel;
        logic at_cur;
        at_sel = ref_sel && (sq == sq_of(ref_sx, ref_sy));
        at_cur = (sq == sq_of(cursor_x, cursor_y));
        return {2'b00, at_sel, at_cur || at_sel, ref_cell[sq]};
    endfunction

    // -------------------- checks and presses
    task automatic check_view(input string name);
        view_word_t exp_w;
        view_word_t got_w;
        logic       bad;
        bad = 1'b0;
        for (int sq = 0; sq < BOARD_CELLS; sq++) begin
            exp_w = expect_word(sq);
            got_w = board_data[sq*VIEW_W +: VIEW_W];
            if (!bad && got_w !== exp_w) begin
                $display("error %s: square %0d expected %h actual %h", name, sq, exp_w, got_w);
                errors++;
                bad = 1'b1;
            end
        end
    endtask

    task automatic run_press(input string name, input coord_t x, input coord_t y,
                             input sound_t exp_snd, input logic pulse);
        presses++;
        @(posedge clk);
        cursor_x   <= x;
        cursor_y   <= y;
        is_pressed <= 1'b1;
        @(posedge clk);    // press edge
        if (pulse) begin
            update_ref(x, y, exp_snd);
        end
        @(negedge clk);
        if (play_sound !== pulse) begin
            $display("error %s: play_sound expected %b actual %b", name, pulse, play_sound);
            errors++;
        end
        if (sound_code !== exp_snd) begin
            $display("error %s: sound_code expected %0d actual %0d", name, exp_snd, sound_code);
            errors++;
        end
        if (state !== ref_state) begin
            $display("error %s: state expected %0d actual %0d", name, ref_state, state);
            errors++;
        end
        check_view(name);
        @(posedge clk);
        is_pressed <= 1'b0;
        @(negedge clk);
        if (play_sound !== 1'b0) begin
            $display("error %s held: play_sound expected 0 actual %b", name, play_sound);
            errors++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic press(input string name, input coord_t x, input coord_t y,
                         input sound_t exp_snd);
        run_press(name, x, y, exp_snd, 1'b1);
    endtask

    // finished game, last sound code stays
    task automatic press_ignored(input string name, input coord_t x, input coord_t y);
        run_press(name, x, y, SND_GAMEOVER, 1'b0);
    endtask

    // -------------------- directed tests
    task automatic test_reset();
        @(negedge clk);
        if (state !== PLAY_STATE) begin
            $display("error reset: state expected %0d actual %0d", PLAY_STATE, state);
            errors++;
        end
        if (play_sound !== 1'b0) begin
            $display("error reset: play_sound expected 0 actual %b", play_sound);
            errors++;
        end
        if (sound_code !== SND_NONE) begin
            $display("error reset: sound_code expected %0d actual %0d", SND_NONE, sound_code);
            errors++;
        end
        check_view("reset");
    endtask

    task automatic test_selection();
        press("sel_black_piece", 3'd4, 3'd6, SND_ILLEGAL);
        press("sel_empty", 3'd4, 3'd3, SND_ILLEGAL);
        press("sel_e2", 3'd4, 3'd1, SND_SELECT);
        press("desel_e2", 3'd4, 3'd1, SND_DESELECT);
        press("sel_e2_again", 3'd4, 3'd1, SND_SELECT);
        press("resel_d2", 3'd3, 3'd1, SND_SELECT);
    endtask

    task automatic test_pawn();
        press("pawn_diag_empty", 3'd4, 3'd2, SND_ILLEGAL);
        press("pawn_double_d4", 3'd3, 3'd3, SND_MOVE);
        press("sel_d7", 3'd3, 3'd6, SND_SELECT);
        press("pawn_double_d5", 3'd3, 3'd4, SND_MOVE);
        press("sel_d4", 3'd3, 3'd3, SND_SELECT);
        press("pawn_onto_piece", 3'd3, 3'd4, SND_ILLEGAL);
        press("sel_c2", 3'd2, 3'd1, SND_SELECT);
        press("pawn_single_c3", 3'd2, 3'd2, SND_MOVE);
    endtask

    task automatic test_pieces();
        press("sel_a8", 3'd0, 3'd7, SND_SELECT);
        press("rook_blocked", 3'd0, 3'd5, SND_ILLEGAL);
        press("sel_b8", 3'd1, 3'd7, SND_SELECT);
        press("knight_c6", 3'd2, 3'd5, SND_MOVE);
        press("sel_f1", 3'd5, 3'd0, SND_SELECT);
        press("bishop_blocked", 3'd1, 3'd4, SND_ILLEGAL);    // e2 still in the way
        press("sel_e2_pawn", 3'd4, 3'd1, SND_SELECT);
        press("pawn_e3", 3'd4, 3'd2, SND_MOVE);
        press("sel_h7", 3'd7, 3'd6, SND_SELECT);
        press("pawn_h6", 3'd7, 3'd5, SND_MOVE);
        press("sel_f1_again", 3'd5, 3'd0, SND_SELECT);
        press("bishop_b5", 3'd1, 3'd4, SND_MOVE);
        press("sel_a7", 3'd0, 3'd6, SND_SELECT);
        press("pawn_a6", 3'd0, 3'd5, SND_MOVE);
        press("sel_d1", 3'd3, 3'd0, SND_SELECT);
        press("queen_h5", 3'd7, 3'd4, SND_MOVE);
    endtask

    task automatic test_capture();
        cell_t got;
        press("sel_c6", 3'd2, 3'd5, SND_SELECT);
        press("knight_takes_d4", 3'd3, 3'd3, SND_CAPTURE);
        got = board_data[sq_of(3'd3, 3'd3)*VIEW_W +: CELL_W];
        if (got !== occupied_cell(BLACK, KNIGHT)) begin
            $display("error capture_d4: cell expected %h actual %h",
                     occupied_cell(BLACK, KNIGHT), got);
            errors++;
        end
    endtask

    task automatic test_game_end();
        press("sel_h5", 3'd7, 3'd4, SND_SELECT);
        press("queen_takes_f7", 3'd5, 3'd6, SND_CAPTURE);
        press("sel_a6", 3'd0, 3'd5, SND_SELECT);
        press("pawn_a5", 3'd0, 3'd4, SND_MOVE);
        press("sel_f7", 3'd5, 3'd6, SND_SELECT);
        press("queen_takes_king", 3'd4, 3'd7, SND_GAMEOVER);
        press_ignored("after_end_e5", 3'd4, 3'd4);
        press_ignored("after_end_e8", 3'd4, 3'd7);
    endtask

    initial begin
        cursor_x   <= '0;
        cursor_y   <= '0;
        is_pressed <= 1'b0;
        load_layout();
        wait (rstn === 1'b1);
        test_reset();
        test_selection();
        test_pawn();
        test_pieces();
        test_capture();
        test_game_end();
        $display("presses %0d, errors %0d", presses, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // period 100
    end

    // reset low for the first two rising edges
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- hdl/play_top.sv
module play_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  chess_pkg::coord_t     cursor_x,
    input  chess_pkg::coord_t     cursor_y,
    input  logic                  is_pressed,
    output play_pkg::game_state_t state,
    output play_pkg::view_flat_t  board_data,
    output play_pkg::sound_t      sound_code,
    output logic                  play_sound
);
    import chess_pkg::*;
    import play_pkg::*;

    board_flat_t board;
    coord_t      sel_x;
    coord_t      sel_y;
    side_t       turn;
    logic        has_selected;
    logic        move_commit;
    logic        move_legal;

    board_store u_board_store (
        .clk         (clk),
        .rstn        (rstn),
        .move_commit (move_commit),
        .sel_x       (sel_x),
        .sel_y       (sel_y),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .board       (board)
    );

    move_check u_move_check (
        .board      (board),
        .sel_x      (sel_x),
        .sel_y      (sel_y),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .turn       (turn),
        .move_legal (move_legal)
    );

    game_ctrl u_game_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .is_pressed   (is_pressed),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .board        (board),
        .move_legal   (move_legal),
        .has_selected (has_selected),
        .sel_x        (sel_x),
        .sel_y        (sel_y),
        .turn         (turn),
        .move_commit  (move_commit),
        .state        (state),
        .sound_code   (sound_code),
        .play_sound   (play_sound)
    );

    board_view u_board_view (
        .board        (board),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .has_selected (has_selected),
        .sel_x        (sel_x),
        .sel_y        (sel_y),
        .board_data   (board_data)
    );

endmodule

//--- hdl/board_view.sv
module board_view (
    input  chess_pkg::board_flat_t board,
    input  chess_pkg::coord_t      cursor_x,
    input  chess_pkg::coord_t      cursor_y,
    input  logic                   has_selected,
    input  chess_pkg::coord_t      sel_x,
    input  chess_pkg::coord_t      sel_y,
    output play_pkg::view_flat_t   board_data
);
    import chess_pkg::*;
    import play_pkg::*;

    for (genvar sq = 0; sq < BOARD_CELLS; sq++) begin : g_sq
        localparam coord_t FILE = coord_t'(sq % 8);
        localparam coord_t RANK = coord_t'(sq / 8);

        cell_t      sq_cell;
        logic       at_cursor;
        logic       at_sel;
        view_word_t word;

        assign sq_cell   = board[sq*CELL_W +: CELL_W];
        assign at_cursor = (cursor_x == FILE) && (cursor_y == RANK);
        assign at_sel    = has_selected && (sel_x == FILE) && (sel_y == RANK);

        always_comb begin
            word                = '0;
            word[CELL_W-1:0]    = sq_cell;
            word[VIEW_MARK_BIT] = at_cursor || at_sel;
            word[VIEW_SEL_BIT]  = at_sel;    // red marker on the picked piece
        end

        assign board_data[sq*VIEW_W +: VIEW_W] = word;
    end

endmodule

//--- hdl/game_ctrl.sv
module game_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    is_pressed,
    input  chess_pkg::coord_t       cursor_x,
    input  chess_pkg::coord_t       cursor_y,
    input  chess_pkg::board_flat_t  board,
    input  logic                    move_legal,
    output logic                    has_selected,
    output chess_pkg::coord_t       sel_x,
    output chess_pkg::coord_t       sel_y,
    output chess_pkg::side_t        turn,
    output logic                    move_commit,
    output play_pkg::game_state_t   state,
    output play_pkg::sound_t        sound_code,
    output logic                    play_sound
);
    import chess_pkg::*;
    import play_pkg::*;

    logic  prev_pressed;
    logic  press_edge;
    cell_t cur_cell;
    logic  cur_own;
    logic  cur_is_sel;
    logic  target_king;

    assign press_edge = is_pressed & ~prev_pressed;

    // -------------------- cursor decode
    assign cur_cell    = board[{cursor_y, cursor_x} * CELL_W +: CELL_W];
    assign cur_own     = cell_occ(cur_cell) && (cell_side(cur_cell) == turn);
    assign cur_is_sel  = has_selected && (cursor_x == sel_x) && (cursor_y == sel_y);
    assign target_king = cell_occ(cur_cell) && (cell_piece(cur_cell) == KING);

    // own-piece targets re-select instead of moving
    assign move_commit = press_edge && (state == PLAY_STATE) && has_selected &&
                         !cur_is_sel && !cur_own && move_legal;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prev_pressed  <= 1'b0;
            has_selected  <= 1'b0;
            sel_x         <= 3'd0;
            sel_y         <= 3'd0;
            turn          <= WHITE;
            state         <= PLAY_STATE;
            sound_code    <= SND_NONE;
            play_sound    <= 1'b0;
        end else begin
            prev_pressed <= is_pressed;
            play_sound   <= 1'b0;    // pulse

            case (state)
                PLAY_STATE: begin
                    if (press_edge) begin
                        play_sound <= 1'b1;    // every press gets a sound
                        if (cur_is_sel) begin
                            has_selected <= 1'b0;
                            sound_code   <= SND_DESELECT;
                        end else if (cur_own) begin
                            has_selected <= 1'b1;    // first pick or re-pick
                            sel_x        <= cursor_x;
                            sel_y        <= cursor_y;
                            sound_code   <= SND_SELECT;
                        end else if (move_commit) begin
                            has_selected <= 1'b0;
                            turn         <= ~turn;
                            if (target_king) begin
                                sound_code <= SND_GAMEOVER;
                                state <= (turn == WHITE) ? WHITE_WIN_STATE : BLACK_WIN_STATE;
                            end else if (cell_occ(cur_cell)) begin
                                sound_code <= SND_CAPTURE;
                            end else begin
                                sound_code <= SND_MOVE;
                            end
                        end else begin
                            sound_code <= SND_ILLEGAL;
                        end
                    end
                end
                DRAW_STATE, BLACK_WIN_STATE, WHITE_WIN_STATE: begin
                    // presses ignored once the game is over
                end
            endcase
        end
    end

endmodule

//--- hdl/move_check.sv
module move_check (
    input  chess_pkg::board_flat_t board,
    input  chess_pkg::coord_t      sel_x,
    input  chess_pkg::coord_t      sel_y,
    input  chess_pkg::coord_t      cursor_x,
    input  chess_pkg::coord_t      cursor_y,
    input  chess_pkg::side_t       turn,
    output logic                   move_legal
);
    import chess_pkg::*;

    cell_t  src_cell;
    cell_t  dst_cell;
    coord_t abs_dx;
    coord_t abs_dy;
    coord_t path_len;
    coord_t home_rank;
    logic   forward;
    logic   moving;
    logic   straight;
    logic   diagonal;
    logic   path_clear;

    function automatic cell_t cell_at(input board_flat_t b, input coord_t x, input coord_t y);
        return b[{y, x} * CELL_W +: CELL_W];
    endfunction

    assign src_cell = cell_at(board, sel_x, sel_y);
    assign dst_cell = cell_at(board, cursor_x, cursor_y);

    assign abs_dx   = (cursor_x > sel_x) ? cursor_x - sel_x : sel_x - cursor_x;
    assign abs_dy   = (cursor_y > sel_y) ? cursor_y - sel_y : sel_y - cursor_y;
    assign path_len = (abs_dx > abs_dy) ? abs_dx : abs_dy;    // valid on lines only

    assign moving   = (abs_dx != 3'd0) || (abs_dy != 3'd0);
    assign straight = (abs_dx == 3'd0) || (abs_dy == 3'd0);
    assign diagonal = (abs_dx == abs_dy);

    // pawn direction and start rank follow the side to move
    assign forward   = (turn == WHITE) ? (cursor_y > sel_y) : (cursor_y < sel_y);
    assign home_rank = (turn == WHITE) ? WHITE_HOME_RANK : BLACK_HOME_RANK;

    // -------------------- path scan
    // walks the squares strictly between source and target
    always_comb begin
        coord_t px;
        coord_t py;
        path_clear = 1'b1;
        for (int k = 1; k < 7; k++) begin
            if (cursor_x > sel_x) begin
                px = sel_x + coord_t'(k);
            end else if (cursor_x < sel_x) begin
                px = sel_x - coord_t'(k);
            end else begin
                px = sel_x;
            end
            if (cursor_y > sel_y) begin
                py = sel_y + coord_t'(k);
            end else if (cursor_y < sel_y) begin
                py = sel_y - coord_t'(k);
            end else begin
                py = sel_y;
            end
            if (k < int'(path_len) && cell_occ(cell_at(board, px, py))) begin
                path_clear = 1'b0;
            end
        end
    end

    // -------------------- piece rules
    always_comb begin
        move_legal = 1'b0;
        case (cell_piece(src_cell))
            PAWN: begin
                if (forward && abs_dx == 3'd0 && abs_dy == 3'd1) begin
                    move_legal = !cell_occ(dst_cell);
                end else if (forward && abs_dx == 3'd0 && abs_dy == 3'd2 && sel_y == home_rank) begin
                    move_legal = !cell_occ(dst_cell) && path_clear;    // both squares empty
                end else if (forward && abs_dx == 3'd1 && abs_dy == 3'd1) begin
                    move_legal = cell_occ(dst_cell);    // diagonal only as capture
                end
            end
            ROOK:    move_legal = moving && straight && path_clear;
            BISHOP:  move_legal = moving && diagonal && path_clear;
            QUEEN:   move_legal = moving && (straight || diagonal) && path_clear;
            KNIGHT:  move_legal = (abs_dx == 3'd1 && abs_dy == 3'd2) ||
                                  (abs_dx == 3'd2 && abs_dy == 3'd1);
            KING:    move_legal = moving && abs_dx <= 3'd1 && abs_dy <= 3'd1;
            default: move_legal = 1'b0;
        endcase
    end

endmodule

//--- hdl/board_store.sv
module board_store (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   move_commit,
    input  chess_pkg::coord_t      sel_x,
    input  chess_pkg::coord_t      sel_y,
    input  chess_pkg::coord_t      cursor_x,
    input  chess_pkg::coord_t      cursor_y,
    output chess_pkg::board_flat_t board
);
    import chess_pkg::*;

    cell_t      cells [BOARD_CELLS];
    logic [5:0] src_sq;
    logic [5:0] dst_sq;

    assign src_sq = {sel_y, sel_x};
    assign dst_sq = {cursor_y, cursor_x};

    // standard opening layout, white on ranks 0 and 1
    function automatic cell_t start_cell(input int sq);
        int     rank;
        side_t  side;
        piece_t piece;
        rank = sq / 8;
        side = (rank >= 4) ? BLACK : WHITE;
        if (rank == 1 || rank == 6) begin
            piece = PAWN;
        end else begin
            case (sq % 8)
                0, 7:    piece = ROOK;
                1, 6:    piece = KNIGHT;
                2, 5:    piece = BISHOP;
                3:       piece = QUEEN;
                default: piece = KING;
            endcase
        end
        if (rank >= 2 && rank <= 5) begin
            return EMPTY_CELL;
        end
        return make_cell(side, piece);
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < BOARD_CELLS; i++) begin
                cells[i] <= start_cell(i);
            end
        end else if (move_commit) begin
            cells[dst_sq] <= cells[src_sq];    // captured piece just gets overwritten
            cells[src_sq] <= EMPTY_CELL;
        end
    end

    // -------------------- flatten
    for (genvar sq = 0; sq < BOARD_CELLS; sq++) begin : g_flat
        assign board[sq*CELL_W +: CELL_W] = cells[sq];
    end

endmodule

//--- hdl/play_pkg.sv
package play_pkg;

    typedef logic [1:0] game_state_t;

    localparam game_state_t DRAW_STATE      = 2'd0;    // encodable, never entered
    localparam game_state_t PLAY_STATE      = 2'd1;
    localparam game_state_t BLACK_WIN_STATE = 2'd2;
    localparam game_state_t WHITE_WIN_STATE = 2'd3;

    typedef logic [2:0] sound_t;

    localparam sound_t SND_NONE     = 3'd0;
    localparam sound_t SND_SELECT   = 3'd1;
    localparam sound_t SND_DESELECT = 3'd2;
    localparam sound_t SND_MOVE     = 3'd3;
    localparam sound_t SND_CAPTURE  = 3'd4;
    localparam sound_t SND_ILLEGAL  = 3'd5;
    localparam sound_t SND_GAMEOVER = 3'd7;

    // -------------------- display word
    // {2'b00, selected, marker, cell}
    localparam int VIEW_W        = 12;
    localparam int VIEW_SEL_BIT  = 9;
    localparam int VIEW_MARK_BIT = 8;

    typedef logic [VIEW_W-1:0] view_word_t;
    typedef logic [chess_pkg::BOARD_CELLS*VIEW_W-1:0] view_flat_t;

endpackage

//--- hdl/chess_pkg.sv
package chess_pkg;

    typedef logic       side_t;
    typedef logic [2:0] piece_t;
    typedef logic [2:0] coord_t;
    typedef logic [7:0] cell_t;    // {3'b000, occupied, side, piece}

    localparam side_t WHITE = 1'b0;
    localparam side_t BLACK = 1'b1;

    localparam piece_t KING   = 3'd1;
    localparam piece_t QUEEN  = 3'd2;
    localparam piece_t BISHOP = 3'd3;
    localparam piece_t KNIGHT = 3'd4;
    localparam piece_t ROOK   = 3'd5;
    localparam piece_t PAWN   = 3'd6;

    localparam int    CELL_W        = 8;
    localparam int    CELL_OCC_BIT  = 4;
    localparam int    CELL_SIDE_BIT = 3;
    localparam cell_t EMPTY_CELL    = 8'h00;

    localparam int BOARD_CELLS = 64;
    typedef logic [BOARD_CELLS*CELL_W-1:0] board_flat_t;    // square = rank*8 + file

    localparam coord_t WHITE_HOME_RANK = 3'd1;
    localparam coord_t BLACK_HOME_RANK = 3'd6;

    // -------------------- cell fields
    function automatic cell_t make_cell(input side_t side, input piece_t piece);
        return {3'b000, 1'b1, side, piece};
    endfunction

    function automatic logic cell_occ(input cell_t c);
        return c[CELL_OCC_BIT];
    endfunction

    function automatic side_t cell_side(input cell_t c);
        return c[CELL_SIDE_BIT];
    endfunction

    function automatic piece_t cell_piece(input cell_t c);
        return c[2:0];
    endfunction

endpackage
